// File: rv_core.f
source/rv_pkg.sv
source/rv_decode.sv
source/rv_ctrl.sv
source/rv_exec.sv
source/rv_mem_stage.sv
source/rv_regfile.sv
source/rv_core.sv
sim/tb_rv_core.sv

// File: sim/rv_stim.txt
// Columns test_kind_rd_data in hex. Kind 1 is an instruction word, kind 2 an
// expected register write (rd, data), kind 3 an expected rise of o_inv_inst.
01_1_00_06400093 // addi x1, x0, 100
01_2_01_00000064
01_1_00_ff900113 // addi x2, x0, -7
01_2_02_fffffff9
01_1_00_55500193 // addi x3, x0, 0x555
01_2_03_00000555
01_1_00_0f000213 // addi x4, x0, 0xf0
01_2_04_000000f0
01_1_00_7ff00293 // addi x5, x0, 0x7ff
01_2_05_000007ff
02_1_00_00208333 // add x6, x1, x2
02_2_06_0000005d
02_1_00_404183b3 // sub x7, x3, x4
02_2_07_00000465
02_1_00_0041f433 // and x8, x3, x4
02_2_08_00000050
02_1_00_0040e4b3 // or x9, x1, x4
02_2_09_000000f4
02_1_00_0051c533 // xor x10, x3, x5
02_2_0a_000002aa
02_1_00_001125b3 // slt x11, x2, x1
02_2_0b_00000001
02_1_00_0020a633 // slt x12, x1, x2
02_2_0c_00000000
03_1_00_001086b3 // add x13, x1, x1
03_2_0d_000000c8
03_1_00_00168733 // add x14, x13, x1
03_2_0e_0000012c
03_1_00_40d707b3 // sub x15, x14, x13
03_2_0f_00000064
03_1_00_00168813 // addi x16, x13, 1
03_2_10_000000c9
03_1_00_00f748b3 // xor x17, x14, x15
03_2_11_00000148
03_1_00_00d80933 // add x18, x16, x13
03_2_12_00000191
03_1_00_00500993 // addi x19, x0, 5
03_2_13_00000005
03_1_00_00900993 // addi x19, x0, 9
03_2_13_00000009
03_1_00_01398a33 // add x20, x19, x19
03_2_14_00000012
03_1_00_fff00a93 // addi x21, x0, -1
03_2_15_ffffffff
03_1_00_00300a93 // addi x21, x0, 3
03_2_15_00000003
03_1_00_00100b13 // addi x22, x0, 1
03_2_16_00000001
03_1_00_016a8bb3 // add x23, x21, x22
03_2_17_00000004
04_1_00_00102023 // sw x1, 0(x0)
04_1_00_00202223 // sw x2, 4(x0)
04_1_00_00002c03 // lw x24, 0(x0)
04_2_18_00000064
04_1_00_018c0cb3 // add x25, x24, x24
04_2_19_000000c8
04_1_00_00402d03 // lw x26, 4(x0)
04_2_1a_fffffff9
04_1_00_401d0db3 // sub x27, x26, x1
04_2_1b_ffffff95
05_1_00_01000e13 // addi x28, x0, 16
05_2_1c_00000010
05_1_00_00ae2623 // sw x10, 12(x28)
05_1_00_01c02e83 // lw x29, 28(x0)
05_2_1d_000002aa
05_1_00_03700013 // addi x0, x0, 55
05_2_00_00000037
05_1_00_00000f33 // add x30, x0, x0
05_2_1e_00000000
05_1_00_00100fb3 // add x31, x0, x1
05_2_1f_00000064
06_1_00_00300393 // addi x7, x0, 3
06_2_07_00000003
06_1_00_ffffffff // unsupported encoding
06_3_00_00000000
06_1_00_00438413 // addi x8, x7, 4
06_2_08_00000007
06_1_00_007404b3 // add x9, x8, x7
06_2_09_0000000a

// File: sim/tb_rv_core.sv
module tb_rv_core
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int stim_depth = 128;
    localparam int mem_words  = 64;

    typedef struct packed
    {
        logic [7:0]  test;
        logic [3:0]  kind;                          // 1 instruction, 2 write, 3 invalid flag.
        logic [7:0]  rd;
        logic [31:0] data;
    } stim_rec_t;

    typedef struct packed
    {
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } wr_exp_t;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_inst_valid;
    logic                  o_inst_ready;
    logic [31:0]           i_inst;
    logic                  o_wb_cyc;
    logic                  o_wb_stb;
    logic                  o_wb_we;
    logic [xlen-1:0]       o_wb_adr;
    logic [xlen-1:0]       o_wb_dat_o;
    logic [3:0]            o_wb_sel;
    logic [xlen-1:0]       i_wb_dat_i;
    logic                  i_wb_ack;
    logic                  o_wr_valid;
    logic [reg_addr_w-1:0] o_wr_rd;
    logic [xlen-1:0]       o_wr_data;
    logic                  o_inv_inst;

    logic [51:0]     stim [stim_depth];
    logic [xlen-1:0] mem [mem_words];
    wr_exp_t         exp_q [$];
    logic [31:0]     rng_state;
    logic            stim_loaded = 1'b0;
    logic            inv_prev;
    logic            wait_armed;
    int              wait_left;
    int              n_inst;
    int              errors;
    int              wr_seen;
    int              wr_expected;
    int              inv_rises;

    rv_core #(.NUM_REGS(32)) u_dut (
        .i_clk, .i_rst_n, .i_inst_valid, .o_inst_ready, .i_inst,
        .o_wb_cyc, .o_wb_stb, .o_wb_we, .o_wb_adr, .o_wb_dat_o, .o_wb_sel,
        .i_wb_dat_i, .i_wb_ack, .o_wr_valid, .o_wr_rd, .o_wr_data, .o_inv_inst);

    always #2 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_write(input logic [reg_addr_w-1:0] rd_got,
                               input logic [reg_addr_w-1:0] rd_exp,
                               input logic [xlen-1:0]       data_got,
                               input logic [xlen-1:0]       data_exp);
        if (rd_got !== rd_exp)
        begin
            errors++;
            $display("ERROR t=%0t o_wr_rd got %0d expected %0d", $time, rd_got, rd_exp);
        end
        if (data_got !== data_exp)
        begin
            errors++;
            $display("ERROR t=%0t o_wr_data got %h expected %h", $time, data_got, data_exp);
        end
    endtask

    // Word accesses enable all four byte lanes.
    task automatic compare_sel(input logic [3:0] sel_got);
        if (sel_got !== 4'hf)
        begin
            errors++;
            $display("ERROR t=%0t o_wb_sel got %h expected %h", $time, sel_got, 4'hf);
        end
    endtask

    task automatic verify_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            errors++;
            $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Holds the word on the port until the core takes it.
    task automatic send_inst(input logic [31:0] word);
        logic taken;
        taken        = 1'b0;
        i_inst       = word;
        i_inst_valid = 1'b1;
        while (!taken)
        begin
            @(negedge i_clk);
            taken = o_inst_ready;
            @(posedge i_clk);
            #1;
        end
        i_inst_valid = 1'b0;
    endtask

    // Wishbone slave with 0 to 3 wait cycles before a one-cycle ack.
    always @(posedge i_clk)
    begin
        #1;
        if (i_wb_ack)
            i_wb_ack = 1'b0;
        else if (o_wb_cyc && o_wb_stb)
        begin
            if (!wait_armed)
            begin
                rng_state  = xorshift32(rng_state);
                wait_left  = rng_state % 4;
                wait_armed = 1'b1;
            end
            if (wait_left == 0)
            begin
                compare_sel(o_wb_sel);
                if (o_wb_we)
                    mem[o_wb_adr[7:2]] = o_wb_dat_o;
                else
                    i_wb_dat_i = mem[o_wb_adr[7:2]];
                i_wb_ack   = 1'b1;
                wait_armed = 1'b0;
            end
            else
                wait_left--;
        end
    end

    // Trace and flag monitor, sampled mid-cycle.
    always @(negedge i_clk)
    begin : trace_monitor
        wr_exp_t head;
        if (i_rst_n)
        begin
            if (o_wr_valid)
            begin
                wr_seen++;
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("Unexpected register write to x%0d at t=%0t", o_wr_rd, $time);
                end
                else
                begin
                    head = exp_q.pop_front();
                    check_write(o_wr_rd, head.rd, o_wr_data, head.data);
                end
            end
            if (o_inv_inst && !inv_prev)
                inv_rises++;
            inv_prev = o_inv_inst;
        end
    end

    initial
    begin : watchdog
        wait (stim_loaded);
        repeat (n_inst * 40 + 100) @(posedge i_clk);
        $display("Watchdog expired at t=%0t, the core stopped making progress", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin : main
        stim_rec_t rec;
        wr_exp_t   w;
        int        idx;
        int        cur_test;
        int        err_start;
        int        inv_start;
        int        inv_exp;
        int        passed;
        int        failed;

        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_wb_dat_i   = '0;
        i_wb_ack     = 1'b0;
        rng_state    = 32'd46635;
        wait_armed   = 1'b0;
        wait_left    = 0;
        inv_prev     = 1'b0;
        errors       = 0;
        wr_seen      = 0;
        wr_expected  = 0;
        inv_rises    = 0;
        passed       = 0;
        failed       = 0;
        foreach (stim[i])
            stim[i] = '0;
        foreach (mem[i])
            mem[i] = 32'ha5000000 ^ (32'(i) * 32'h00010101);
        $readmemh("sim/rv_stim.txt", stim);
        n_inst = 0;
        foreach (stim[i])
            if (stim[i][43:40] == 4'd1)
                n_inst++;
        if (n_inst == 0)
        begin
            errors++;
            $display("Stimulus file sim/rv_stim.txt holds no instructions");
        end
        stim_loaded = 1'b1;

        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        if (o_wb_cyc | o_wb_stb | o_wr_valid | o_inv_inst | o_inst_ready)
        begin
            errors++;
            $display("Outputs are not idle during reset at t=%0t", $time);
        end
        @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        idx = 0;
        while (idx < stim_depth && stim[idx][43:40] != 4'd0)
        begin
            rec       = stim[idx];
            cur_test  = rec.test;
            err_start = errors;
            inv_start = inv_rises;
            inv_exp   = 0;
            while (idx < stim_depth && rec.kind != 4'd0 && rec.test == cur_test)
            begin
                case (rec.kind)
                    4'd1: send_inst(rec.data);
                    4'd2:
                    begin
                        w.rd   = rec.rd[reg_addr_w-1:0];
                        w.data = rec.data;
                        exp_q.push_back(w);
                        wr_expected++;
                    end
                    4'd3: inv_exp++;
                    default:
                    begin
                        errors++;
                        $display("Unknown record kind %0d at stimulus line %0d", rec.kind, idx);
                    end
                endcase
                idx++;
                if (idx < stim_depth)
                    rec = stim[idx];
            end
            while (exp_q.size() != 0)
                @(negedge i_clk);
            repeat (6) @(negedge i_clk);           // Idle window with valid low.
            verify_count("o_inv_inst rises", inv_rises - inv_start, inv_exp);
            if (errors == err_start)
            begin
                passed++;
                $display("test %0d passed", cur_test);
            end
            else
            begin
                failed++;
                $display("test %0d failed with %0d errors", cur_test, errors - err_start);
            end
            @(posedge i_clk);
            #1;
        end

        verify_count("o_wr_valid count", wr_seen, wr_expected);
        $display("%0d tests, %0d passed, %0d failed, %0d writes checked, %0d errors",
                 passed + failed, passed, failed, wr_seen, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: source/rv_core.sv
module rv_core
    import rv_pkg::*;
#(
    parameter int NUM_REGS = 32
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_inst_valid,
    output logic                  o_inst_ready,
    input  logic [31:0]           i_inst,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic                  o_wb_we,
    output logic [xlen-1:0]       o_wb_adr,
    output logic [xlen-1:0]       o_wb_dat_o,
    output logic [3:0]            o_wb_sel,
    input  logic [xlen-1:0]       i_wb_dat_i,
    input  logic                  i_wb_ack,
    output logic                  o_wr_valid,
    output logic [reg_addr_w-1:0] o_wr_rd,
    output logic [xlen-1:0]       o_wr_data,
    output logic                  o_inv_inst
);

    logic                  decode_stall, decode_flush, alu1_flush, alu2_flush;
    logic                  need_pause, has_inp, inst_sup;
    logic [reg_addr_w-1:0] rs1, rs2;
    rs_bp_t                rs1_bp, rs2_bp;
    hz_src_t               alu1_src, alu2_src, mem_src, wr_src;
    stage_t                alu1, ex, wr;
    logic [xlen-1:0]       rf_rs1_data, rf_rs2_data, alu2_res, mem_res, wr_res;

    rv_decode u_decode (
        .i_clk, .i_rst_n, .i_inst_valid, .i_inst,
        .i_stall(decode_stall), .i_flush(decode_flush), .i_alu1_flush(alu1_flush),
        .i_rs1_bp(rs1_bp), .i_rs2_bp(rs2_bp),
        .i_rf_rs1_data(rf_rs1_data), .i_rf_rs2_data(rf_rs2_data),
        .i_alu2_res(alu2_res), .i_mem_res(mem_res), .i_wr_res(wr_res),
        .o_inst_ready, .o_rs1(rs1), .o_rs2(rs2), .o_has_inp(has_inp),
        .o_inst_sup(inst_sup), .o_alu1(alu1));

    rv_ctrl u_ctrl (
        .i_clk, .i_rst_n, .i_rs1(rs1), .i_rs2(rs2), .i_has_inp(has_inp),
        .i_inst_sup(inst_sup), .i_alu1_src(alu1_src), .i_alu2_src(alu2_src),
        .i_mem_src(mem_src), .i_wr_src(wr_src), .i_need_pause(need_pause),
        .o_decode_stall(decode_stall), .o_decode_flush(decode_flush),
        .o_alu1_flush(alu1_flush), .o_alu2_flush(alu2_flush),
        .o_rs1_bp(rs1_bp), .o_rs2_bp(rs2_bp), .o_inv_inst);

    rv_exec u_exec (
        .i_clk, .i_rst_n, .i_alu1(alu1), .i_hold(need_pause), .i_alu2_flush(alu2_flush),
        .o_alu1_src(alu1_src), .o_alu2_src(alu2_src), .o_alu2(ex), .o_alu2_res(alu2_res));

    rv_mem_stage u_mem (
        .i_clk, .i_rst_n, .i_ex(ex), .i_wb_dat_i, .i_wb_ack,
        .o_wb_cyc, .o_wb_stb, .o_wb_we, .o_wb_adr, .o_wb_dat_o, .o_wb_sel,
        .o_need_pause(need_pause), .o_mem_src(mem_src), .o_wr(wr), .o_mem_res(mem_res));

    rv_regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
        .i_clk, .i_rst_n, .i_wr(wr), .i_rs1(rs1), .i_rs2(rs2),
        .o_rs1_data(rf_rs1_data), .o_rs2_data(rf_rs2_data),
        .o_wr_src(wr_src), .o_wr_res(wr_res), .o_wr_valid, .o_wr_rd, .o_wr_data);

endmodule

// File: source/rv_ctrl.sv
module rv_ctrl
    import rv_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [reg_addr_w-1:0] i_rs1,
    input  logic [reg_addr_w-1:0] i_rs2,
    input  logic                  i_has_inp,
    input  logic                  i_inst_sup,
    input  hz_src_t               i_alu1_src,
    input  hz_src_t               i_alu2_src,
    input  hz_src_t               i_mem_src,
    input  hz_src_t               i_wr_src,
    input  logic                  i_need_pause,
    output logic                  o_decode_stall,
    output logic                  o_decode_flush,
    output logic                  o_alu1_flush,
    output logic                  o_alu2_flush,
    output rs_bp_t                o_rs1_bp,
    output rs_bp_t                o_rs2_bp,
    output logic                  o_inv_inst
);

    logic       rs1_alu1, rs1_alu2, rs1_mem, rs1_wr;
    logic       rs2_alu1, rs2_alu2, rs2_mem, rs2_wr;
    logic       load_hit;
    logic [1:0] sup_q;

    // Register x0 never matches a producer.
    function automatic logic hit(hz_src_t s, logic [reg_addr_w-1:0] rs);
        return s.reg_write & (|s.rd) & (s.rd == rs);
    endfunction

    function automatic logic ld_hit(hz_src_t s, logic [reg_addr_w-1:0] r1,
                                    logic [reg_addr_w-1:0] r2);
        return s.mem_rd & (|s.rd) & ((s.rd == r1) | (s.rd == r2));
    endfunction

    assign rs1_alu1 = hit(i_alu1_src, i_rs1);
    assign rs1_alu2 = hit(i_alu2_src, i_rs1);
    assign rs1_mem  = hit(i_mem_src,  i_rs1);
    assign rs1_wr   = hit(i_wr_src,   i_rs1);
    assign rs2_alu1 = hit(i_alu1_src, i_rs2);
    assign rs2_alu2 = hit(i_alu2_src, i_rs2);
    assign rs2_mem  = hit(i_mem_src,  i_rs2);
    assign rs2_wr   = hit(i_wr_src,   i_rs2);

    assign load_hit = ld_hit(i_alu1_src, i_rs1, i_rs2) |
                      ld_hit(i_alu2_src, i_rs1, i_rs2) |
                      ld_hit(i_mem_src,  i_rs1, i_rs2);

    assign o_decode_stall = !i_rst_n | i_need_pause | !i_has_inp |
                            rs1_alu1 | rs2_alu1 | load_hit;
    assign o_decode_flush = !i_rst_n;
    assign o_alu1_flush   = !i_rst_n | (o_decode_stall & !i_need_pause); // Bubble, not on pause.
    assign o_alu2_flush   = !i_rst_n;

    // Newest producer wins.
    assign o_rs1_bp.alu2   = rs1_alu2;
    assign o_rs1_bp.memory = rs1_mem & !rs1_alu2;
    assign o_rs1_bp.write  = rs1_wr & !rs1_alu2 & !rs1_mem;
    assign o_rs2_bp.alu2   = rs2_alu2;
    assign o_rs2_bp.memory = rs2_mem & !rs2_alu2;
    assign o_rs2_bp.write  = rs2_wr & !rs2_alu2 & !rs2_mem;

    // Supported bits follow accepted instructions to the alu2 slot.
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            sup_q <= '1;
        else if (!o_decode_stall)
            sup_q <= {sup_q[0], i_inst_sup};
    end

    assign o_inv_inst = !sup_q[1];

endmodule

// File: source/rv_decode.sv
module rv_decode
    import rv_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_inst_valid,
    input  logic [31:0]           i_inst,
    input  logic                  i_stall,
    input  logic                  i_flush,
    input  logic                  i_alu1_flush,
    input  rs_bp_t                i_rs1_bp,
    input  rs_bp_t                i_rs2_bp,
    input  logic [xlen-1:0]       i_rf_rs1_data,
    input  logic [xlen-1:0]       i_rf_rs2_data,
    input  logic [xlen-1:0]       i_alu2_res,
    input  logic [xlen-1:0]       i_mem_res,
    input  logic [xlen-1:0]       i_wr_res,
    output logic                  o_inst_ready,
    output logic [reg_addr_w-1:0] o_rs1,
    output logic [reg_addr_w-1:0] o_rs2,
    output logic                  o_has_inp,
    output logic                  o_inst_sup,
    output stage_t                o_alu1
);

    logic [31:0]     inst_q;
    logic            inst_v;
    rv_op_e          op;
    logic            use_rs2;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    stage_t          nxt;
    stage_t          alu1_q;

    // An empty decode slot may always take a word, except in reset.
    assign o_inst_ready = !i_flush & (!i_stall | !inst_v);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            inst_v <= 1'b0;
            inst_q <= '0;
        end
        else if (i_flush)
            inst_v <= 1'b0;
        else if (!i_stall | !inst_v)
        begin
            inst_v <= i_inst_valid;                 // Empty when nothing arrives.
            inst_q <= i_inst;
        end
    end

    assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
    assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};

    always_comb
    begin
        op      = INV;
        use_rs2 = 1'b0;
        case (inst_q[6:0])
            7'b0110011:
            begin
                use_rs2 = 1'b1;
                case ({inst_q[31:25], inst_q[14:12]})
                    10'b0000000_000: op = ADD;
                    10'b0100000_000: op = SUB;
                    10'b0000000_111: op = AND;
                    10'b0000000_110: op = OR;
                    10'b0000000_100: op = XOR;
                    10'b0000000_010: op = SLT;
                    default:         op = INV;
                endcase
            end
            7'b0010011: if (inst_q[14:12] == 3'b000) op = ADDI;
            7'b0000011: if (inst_q[14:12] == 3'b010) op = LW;
            7'b0100011:
            begin
                use_rs2 = 1'b1;
                if (inst_q[14:12] == 3'b010)
                    op = SW;
            end
            default: op = INV;
        endcase
    end

    // Only real source registers are reported to the hazard logic.
    assign o_rs1      = (inst_v && op != INV) ? inst_q[19:15] : '0;
    assign o_rs2      = (inst_v && op != INV && use_rs2) ? inst_q[24:20] : '0;
    assign o_has_inp  = inst_v;
    assign o_inst_sup = !inst_v | (op != INV);

    assign rs1_val = i_rs1_bp.alu2   ? i_alu2_res :
                     i_rs1_bp.memory ? i_mem_res  :
                     i_rs1_bp.write  ? i_wr_res   : i_rf_rs1_data;
    assign rs2_val = i_rs2_bp.alu2   ? i_alu2_res :
                     i_rs2_bp.memory ? i_mem_res  :
                     i_rs2_bp.write  ? i_wr_res   : i_rf_rs2_data;

    always_comb
    begin
        nxt           = '0;
        nxt.valid     = inst_v;
        nxt.op        = op;
        nxt.rd        = inst_q[11:7];
        nxt.reg_write = (op != INV) && (op != SW);
        nxt.mem_rd    = (op == LW);
        nxt.mem_wr    = (op == SW);
        nxt.a         = rs1_val;
        nxt.b         = use_rs2 ? rs2_val : imm_i;  // SW keeps store data here.
        nxt.res       = (op == SW) ? imm_s : '0;    // Store offset rides in res.
    end

    // A pause holds alu1 since ctrl then does not flush it.
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            alu1_q <= '0;
        else if (i_alu1_flush)
            alu1_q <= '0;
        else if (!i_stall)
            alu1_q <= nxt;
    end

    assign o_alu1 = alu1_q;

    // At most one producer may drive each operand.
    a_bp_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(i_rs1_bp) && $onehot0(i_rs2_bp));

    a_rst_ready: assert property (@(posedge i_clk)
        !i_rst_n |-> !o_inst_ready);

endmodule

// File: source/rv_exec.sv
module rv_exec
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  stage_t          i_alu1,
    input  logic            i_hold,
    input  logic            i_alu2_flush,
    output hz_src_t         o_alu1_src,
    output hz_src_t         o_alu2_src,
    output stage_t          o_alu2,
    output logic [xlen-1:0] o_alu2_res
);

    stage_t alu1_out;
    stage_t alu2_q;
    stage_t alu2_out;
    stage_t mem_q;
    logic   lt;

    always_comb
    begin
        alu1_out = i_alu1;
        case (i_alu1.op)
            ADD, ADDI, LW: alu1_out.res = i_alu1.a + i_alu1.b;
            SW:            alu1_out.res = i_alu1.a + i_alu1.res;  // Address.
            SUB, SLT:      alu1_out.res = i_alu1.a - i_alu1.b;
            AND:           alu1_out.res = i_alu1.a & i_alu1.b;
            OR:            alu1_out.res = i_alu1.a | i_alu1.b;
            XOR:           alu1_out.res = i_alu1.a ^ i_alu1.b;
            default:       alu1_out.res = '0;
        endcase
    end

    // Signed compare from the difference made in alu1.
    assign lt = (alu2_q.a[xlen-1] ^ alu2_q.b[xlen-1]) ? alu2_q.a[xlen-1] :
                alu2_q.res[xlen-1];

    always_comb
    begin
        alu2_out = alu2_q;
        if (alu2_q.op == SLT)
            alu2_out.res = {{(xlen-1){1'b0}}, lt};
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            alu2_q <= '0;
            mem_q  <= '0;
        end
        else if (i_alu2_flush)
        begin
            alu2_q <= '0;
            mem_q  <= '0;
        end
        else if (!i_hold)
        begin
            alu2_q <= alu1_out;
            mem_q  <= alu2_out;
        end
    end

    assign o_alu1_src = hz_of(i_alu1);
    assign o_alu2_src = hz_of(alu2_q);
    assign o_alu2     = mem_q;
    assign o_alu2_res = alu2_out.res;

endmodule

// File: source/rv_mem_stage.sv
module rv_mem_stage
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  stage_t          i_ex,
    input  logic [xlen-1:0] i_wb_dat_i,
    input  logic            i_wb_ack,
    output logic            o_wb_cyc,
    output logic            o_wb_stb,
    output logic            o_wb_we,
    output logic [xlen-1:0] o_wb_adr,
    output logic [xlen-1:0] o_wb_dat_o,
    output logic [3:0]      o_wb_sel,
    output logic            o_need_pause,
    output hz_src_t         o_mem_src,
    output stage_t          o_wr,
    output logic [xlen-1:0] o_mem_res
);

    typedef enum logic
    {
        IDLE,
        BUS
    } mem_state_e;

    mem_state_e state;
    logic       mem_op;
    logic       done;

    assign mem_op = i_ex.valid & (i_ex.mem_rd | i_ex.mem_wr);
    assign done   = (state == BUS) & i_wb_ack;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state      <= IDLE;
            o_wb_cyc   <= 1'b0;
            o_wb_we    <= 1'b0;
            o_wb_adr   <= '0;
            o_wb_dat_o <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (mem_op)
                    begin
                        state      <= BUS;
                        o_wb_cyc   <= 1'b1;
                        o_wb_we    <= i_ex.mem_wr;
                        o_wb_adr   <= i_ex.res;
                        o_wb_dat_o <= i_ex.b;       // Store data.
                    end
                BUS:
                    if (i_wb_ack)
                    begin
                        state    <= IDLE;
                        o_wb_cyc <= 1'b0;
                    end
                default: state <= IDLE;
            endcase
        end
    end

    assign o_wb_stb = o_wb_cyc;
    assign o_wb_sel = 4'hf;                         // Word accesses only.

    // Held until the ack edge, so the pipeline moves on with the data.
    assign o_need_pause = mem_op & !done;

    always_comb
    begin
        o_wr       = i_ex;
        o_wr.valid = i_ex.valid & !o_need_pause;
        if (i_ex.mem_rd)
            o_wr.res = i_wb_dat_i;
    end

    assign o_mem_src = hz_of(i_ex);
    assign o_mem_res = i_ex.res;

    // The upstream hold must keep the access in place for the whole cycle.
    a_cyc_entry: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_cyc |-> mem_op && (o_wb_we == i_ex.mem_wr));

endmodule

// File: source/rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef enum logic [3:0]
    {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        ADDI,
        LW,
        SW,
        INV
    } rv_op_e;

    typedef struct packed
    {
        logic                  valid;
        rv_op_e                op;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        logic                  mem_rd;
        logic                  mem_wr;
        logic [xlen-1:0]       a;
        logic [xlen-1:0]       b;
        logic [xlen-1:0]       res;         // Result, or byte address for LW/SW.
    } stage_t;

    typedef struct packed
    {
        logic alu2;
        logic memory;
        logic write;
    } rs_bp_t;

    typedef struct packed
    {
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        logic                  mem_rd;
    } hz_src_t;

    // Empty stages report no destination.
    function automatic hz_src_t hz_of(stage_t s);
        hz_src_t h;
        h.rd        = s.rd;
        h.reg_write = s.valid & s.reg_write;
        h.mem_rd    = s.valid & s.mem_rd;
        return h;
    endfunction

endpackage

// File: source/rv_regfile.sv
module rv_regfile
    import rv_pkg::*;
#(
    parameter int NUM_REGS = 32
)
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  stage_t                i_wr,
    input  logic [reg_addr_w-1:0] i_rs1,
    input  logic [reg_addr_w-1:0] i_rs2,
    output logic [xlen-1:0]       o_rs1_data,
    output logic [xlen-1:0]       o_rs2_data,
    output hz_src_t               o_wr_src,
    output logic [xlen-1:0]       o_wr_res,
    output logic                  o_wr_valid,
    output logic [reg_addr_w-1:0] o_wr_rd,
    output logic [xlen-1:0]       o_wr_data
);

    localparam int idx_w = $clog2(NUM_REGS);

    stage_t          wr_q;
    logic [xlen-1:0] regs [NUM_REGS];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            wr_q <= '0;
        else
            wr_q <= i_wr;
    end

    always_ff @(posedge i_clk)
    begin
        if (o_wr_valid && wr_q.rd != '0)
            regs[wr_q.rd[idx_w-1:0]] <= wr_q.res;   // x0 is never stored.
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1[idx_w-1:0]];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2[idx_w-1:0]];

    assign o_wr_src   = hz_of(wr_q);
    assign o_wr_res   = wr_q.res;
    assign o_wr_valid = wr_q.valid & wr_q.reg_write;
    assign o_wr_rd    = wr_q.rd;
    assign o_wr_data  = wr_q.res;

endmodule
